//--- Bender.yml
package:
  name: fxp_divider

sources:
  # Shared package first, then the divider blocks and the top level
  - common/div_pkg.sv
  - divider/div_ctrl.sv
  - divider/div_iter_counter.sv
  - divider/div_operand_prep.sv
  - divider/div_datapath.sv
  - divider/div_result_fmt.sv
  - hdl/fxp_divider_top.sv

  # Testbench, top module tb_fxp_divider
  - target: test
    files:
      - sim/fxp_divider_assertions.sv
      - sim/tb_fxp_divider.sv

//--- common/div_pkg.sv
////////////////////
// Shared widths and types of the fixed-point divider. Widths are fixed at
// elaboration, and no run-time width selection exists
////////////////////

`default_nettype none

package div_pkg;

  // Operand and result width in bits
  localparam int N_BITS = 16;

  // Number of fractional bits in the quotient
  localparam int Q_BITS = 8;

  // The partial remainder holds the dividend shifted up by Q_BITS
  localparam int ACC_BITS = N_BITS + Q_BITS;

  // The divisor field needs room for a full magnitude shifted up by ACC_BITS-1,
  // plus one zero guard bit at the top
  localparam int DIVR_BITS = 2 * N_BITS + Q_BITS;

  // One restoring step per quotient bit
  localparam int STEPS = ACC_BITS;

  // Wide enough for STEPS-1, the load value of the step counter
  localparam int CNT_BITS = $clog2(STEPS);

  // Controller states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } div_state_e;

  // Ingress request, two's-complement operands
  typedef struct packed {
    logic signed [N_BITS-1:0] dividend;
    logic signed [N_BITS-1:0] divisor;
  } div_req_t;

  // Conditioned operands, magnitudes aligned for the first compare
  typedef struct packed {
    logic [ACC_BITS-1:0]  rem;
    logic [DIVR_BITS-1:0] divr;
    logic                 sign;
  } div_mag_t;

  // Unsigned result of the iteration, before sign restore
  typedef struct packed {
    logic [ACC_BITS-1:0] quot;
    logic [ACC_BITS-1:0] rem;
  } div_raw_t;

  // Egress response
  typedef struct packed {
    logic signed [N_BITS-1:0] quotient;
    logic signed [N_BITS-1:0] remainder;
    logic                     overflow;
  } div_rsp_t;

endpackage

`default_nettype wire

//--- compile.f
common/div_pkg.sv
divider/div_ctrl.sv
divider/div_iter_counter.sv
divider/div_operand_prep.sv
divider/div_datapath.sv
divider/div_result_fmt.sv
hdl/fxp_divider_top.sv
sim/fxp_divider_assertions.sv
sim/tb_fxp_divider.sv

//--- divider/div_ctrl.sv
////////////////////
// Sequencing FSM of the divider. One division is in flight at a time and
// there is no egress back-pressure
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  logic last,
  output logic load,
  output logic step,
  output logic finish
);

  div_pkg::div_state_e state;
  div_pkg::div_state_e state_nxt;

  ////////////////////
  // Output decode
  ////////////////////

  // Ingress is open only while nothing is in flight
  assign in_ready = (state == div_pkg::IDLE);

  // The accept condition loads operands and the step counter
  assign load = in_ready && in_valid;

  // Every RUN cycle performs one restoring step
  assign step = (state == div_pkg::RUN);

  // DONE lasts one cycle and tells the formatter to capture the result
  assign finish = (state == div_pkg::DONE);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      div_pkg::IDLE: begin
        // Leave IDLE only on an accepted request
        if (load) begin
          state_nxt = div_pkg::RUN;
        end
      end
      div_pkg::RUN: begin
        // The counter flags the final step, which still executes this cycle
        if (step && last) begin
          state_nxt = div_pkg::DONE;
        end
      end
      div_pkg::DONE: begin
        state_nxt = div_pkg::IDLE;
      end
      default: begin
        state_nxt = div_pkg::IDLE;
      end
    endcase
  end

  // State register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= div_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

//--- divider/div_datapath.sv
////////////////////
// Restoring compare-subtract datapath. One quotient bit per step, MSB first.
// A zero divisor yields an all-ones quotient
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_datapath (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load,
  input  logic              step,
  input  div_pkg::div_mag_t mag,
  output div_pkg::div_raw_t raw,
  output logic              sign
);

  // Partial remainder, shifted divisor and quotient shift register
  logic [div_pkg::ACC_BITS-1:0]  rem_q;
  logic [div_pkg::DIVR_BITS-1:0] divr_q;
  logic [div_pkg::ACC_BITS-1:0]  quot_q;
  logic                          sign_q;

  // Remainder zero-extended to the divisor width for the compare
  logic [div_pkg::DIVR_BITS-1:0] rem_ext;
  logic                          fits;
  logic [div_pkg::ACC_BITS-1:0]  rem_sub;

  ////////////////////
  // Compare and subtract
  ////////////////////

  assign rem_ext = {{(div_pkg::DIVR_BITS - div_pkg::ACC_BITS){1'b0}}, rem_q};

  // The shifted divisor fits when it is not larger than what is left
  assign fits = (rem_ext >= divr_q);

  // When it fits, its upper bits are zero, so the low slice is exact
  assign rem_sub = rem_q - divr_q[div_pkg::ACC_BITS-1:0];

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rem_q  <= '0;
      divr_q <= '0;
      quot_q <= '0;
      sign_q <= 1'b0;
    end else if (load) begin
      // Fresh operands, the quotient starts empty
      rem_q  <= mag.rem;
      divr_q <= mag.divr;
      quot_q <= '0;
      sign_q <= mag.sign;
    end else if (step) begin
      if (fits) begin
        rem_q  <= rem_sub;
        quot_q <= {quot_q[div_pkg::ACC_BITS-2:0], 1'b1};
      end else begin
        quot_q <= {quot_q[div_pkg::ACC_BITS-2:0], 1'b0};
      end
      // Next step tests the next lower quotient weight
      divr_q <= divr_q >> 1;
    end
  end

  // What remains after the last step is the remainder
  assign raw  = '{quot: quot_q, rem: rem_q};
  assign sign = sign_q;

endmodule

`default_nettype wire

//--- divider/div_iter_counter.sv
////////////////////
// Restoring step counter. Loads STEPS-1 and holds at zero once the last
// step has been flagged
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_iter_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic step,
  output logic last
);

  logic [div_pkg::CNT_BITS-1:0] count;

  // The step that sees a zero count is the final one
  assign last = (count == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      // Steps remaining after the first one
      count <= div_pkg::CNT_BITS'(div_pkg::STEPS - 1);
    end else if (step && !last) begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- divider/div_operand_prep.sv
////////////////////
// Combinational operand conditioning. The most negative input keeps its
// full N-bit magnitude
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
  input  div_pkg::div_req_t req,
  output div_pkg::div_mag_t mag
);

  logic [div_pkg::N_BITS-1:0] a_mag;
  logic [div_pkg::N_BITS-1:0] b_mag;
  logic                       a_neg;
  logic                       b_neg;

  assign a_neg = req.dividend[div_pkg::N_BITS-1];
  assign b_neg = req.divisor[div_pkg::N_BITS-1];

  // Two's-complement magnitudes, read as unsigned so that -2^(N-1) maps to 2^(N-1)
  assign a_mag = a_neg ? (~req.dividend + 1'b1) : req.dividend;
  assign b_mag = b_neg ? (~req.divisor + 1'b1) : req.divisor;

  // The dividend starts at bit Q_BITS, which supplies the fractional zeros.
  // The divisor sits right below a zero guard bit, so the first compare is
  // against B * 2^(STEPS-1), the weight of the top quotient bit.
  // The sign travels with the operands and is restored after the last step
  assign mag = '{
    rem:  {a_mag, {div_pkg::Q_BITS{1'b0}}},
    divr: {1'b0, b_mag, {(div_pkg::ACC_BITS - 1){1'b0}}},
    sign: a_neg ^ b_neg
  };

endmodule

`default_nettype wire

//--- divider/div_result_fmt.sv
////////////////////
// Output register. Results are truncated to N bits, and overflow is flagged
// whenever the quotient magnitude exceeds 2^(N-1)-1
////////////////////

`timescale 1ns/1ps
`default_nettype none

module div_result_fmt (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              finish,
  input  div_pkg::div_raw_t raw,
  input  logic              sign,
  output logic              out_valid,
  output div_pkg::div_rsp_t out_rsp
);

  logic [div_pkg::N_BITS-1:0] quot_trunc;
  logic [div_pkg::N_BITS-1:0] rem_trunc;
  logic [div_pkg::N_BITS-1:0] quot_signed;
  logic [div_pkg::N_BITS-1:0] rem_signed;
  logic                       ovf;

  // Magnitudes cut to the output width
  assign quot_trunc = raw.quot[div_pkg::N_BITS-1:0];
  assign rem_trunc  = raw.rem[div_pkg::N_BITS-1:0];

  // Sign restore applies to both results
  assign quot_signed = sign ? (~quot_trunc + 1'b1) : quot_trunc;
  assign rem_signed  = sign ? (~rem_trunc + 1'b1) : rem_trunc;

  // Any set bit at or above N-1 puts the magnitude out of the positive range,
  // which also covers -2^(N-1)
  assign ovf = |raw.quot[div_pkg::ACC_BITS-1:div_pkg::N_BITS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_rsp   <= '0;
    end else begin
      // Single-cycle pulse, DONE lasts one cycle
      out_valid <= finish;
      // The response holds until the next division completes
      if (finish) begin
        out_rsp <= '{quotient: quot_signed, remainder: rem_signed, overflow: ovf};
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/fxp_divider_top.sv
////////////////////
// Signed fixed-point divider. Latency is STEPS+1 clocks from accept to
// out_valid, and results that are not taken are overwritten
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fxp_divider_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  div_pkg::div_req_t in_req,
  output logic              out_valid,
  output div_pkg::div_rsp_t out_rsp
);

  // Control strobes
  logic load;
  logic step;
  logic last;
  logic finish;

  // Datapath links
  div_pkg::div_mag_t mag;
  div_pkg::div_raw_t raw;
  logic              sign;

  div_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .last     (last),
    .load     (load),
    .step     (step),
    .finish   (finish)
  );

  div_iter_counter u_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .step  (step),
    .last  (last)
  );

  // Operands are only captured on the accepting edge
  div_operand_prep u_prep (
    .req (in_req),
    .mag (mag)
  );

  div_datapath u_datapath (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .step  (step),
    .mag   (mag),
    .raw   (raw),
    .sign  (sign)
  );

  div_result_fmt u_fmt (
    .clk       (clk),
    .rst_n     (rst_n),
    .finish    (finish),
    .raw       (raw),
    .sign      (sign),
    .out_valid (out_valid),
    .out_rsp   (out_rsp)
  );

endmodule

`default_nettype wire

//--- sim/fxp_divider_assertions.sv
////////////////////
// Protocol checks for the divider top level, attached with bind.
// Assumes one division in flight and no egress back-pressure
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fxp_divider_assertions (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic in_valid,
  input wire logic in_ready,
  input wire logic out_valid
);

  // Edges from the accepting edge to the edge that raises out_valid
  localparam int LAT = div_pkg::STEPS + 1;

  logic        accept;
  // Number of failed assertion attempts
  int unsigned fail_cnt;

  assign accept = in_valid && in_ready;

  initial begin
    fail_cnt = 0;
  end

  ////////////////////
  // Egress pulse
  ////////////////////

  // The response strobe never stretches past one cycle
  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |=> !out_valid)
    else begin
      $error("out_valid held for more than one cycle");
      fail_cnt++;
    end

  // The response arrives after a fixed latency with no early pulse in between
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> (!out_valid)[*LAT] ##1 out_valid)
    else begin
      $error("out_valid did not follow the accept after STEPS+1 edges");
      fail_cnt++;
    end

  ////////////////////
  // Ingress handshake
  ////////////////////

  // Ingress stays closed for the whole division and reopens with out_valid
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> (!in_ready)[*LAT] ##1 in_ready)
    else begin
      $error("in_ready rose during a division or stayed low after it");
      fail_cnt++;
    end

  // Out of reset the divider is idle and has nothing to report
  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> (in_ready && !out_valid))
    else begin
      $error("divider not idle after reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- sim/tb_fxp_divider.sv
////////////////////
// Random-stimulus testbench of the fixed-point divider, checked against a
// wide-integer model. Operand width is taken as 16 bits in the corner table
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_fxp_divider;

  localparam int N_RAND   = 160;
  localparam int N_SMALL  = 80;
  localparam int N_CORNER = 10;
  localparam int N_B2B    = 40;
  localparam int NUM_REQ  = N_RAND + N_SMALL + N_CORNER + N_B2B;
  // Each request needs at most STEPS+2 edges plus a one-cycle gap
  localparam int TIMEOUT_CYCLES = NUM_REQ * (div_pkg::STEPS + 4) + 100;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  div_pkg::div_req_t in_req;
  logic              out_valid;
  div_pkg::div_rsp_t out_rsp;

  // Scoreboard state
  div_pkg::div_rsp_t exp_q[$];
  int unsigned       acc_q[$];
  div_pkg::div_rsp_t exp_rsp;
  int unsigned       acc_cycle;
  int unsigned       cycle_cnt;
  int unsigned       last_accept;
  int                n_checks;
  int                n_mismatch;
  int                n_other;
  logic [31:0]       lfsr_state;

  // Division by zero and most negative operands
  logic [div_pkg::N_BITS-1:0] corner_a [0:N_CORNER-1] = '{
    16'h8000, 16'h3039, 16'hffff, 16'h0000, 16'h8000,
    16'h8000, 16'h7fff, 16'h0001, 16'h8000, 16'h8000
  };
  logic [div_pkg::N_BITS-1:0] corner_b [0:N_CORNER-1] = '{
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h8000,
    16'h0001, 16'h8000, 16'h8000, 16'hffff, 16'h0100
  };

  fxp_divider_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_rsp   (out_rsp)
  );

  bind fxp_divider_top fxp_divider_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid)
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Right-shifting Galois LFSR that is stepped once per random bit
  function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
    lfsr_advance = s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_advance(lfsr_state);
    end
  endtask

  // Reference result from plain integer division on magnitudes
  function automatic div_pkg::div_rsp_t model_divide(input div_pkg::div_req_t req);
    longint                     a;
    longint                     b;
    longint                     qmag;
    longint                     rmag;
    logic                       sgn;
    logic [div_pkg::N_BITS-1:0] q16;
    logic [div_pkg::N_BITS-1:0] r16;
    div_pkg::div_rsp_t          r;
    a = longint'($signed(req.dividend));
    b = longint'($signed(req.divisor));
    sgn = req.dividend[div_pkg::N_BITS-1] ^ req.divisor[div_pkg::N_BITS-1];
    if (a < 0) a = -a;
    if (b < 0) b = -b;
    if (b == 0) begin
      // A zero divisor gives an all-ones quotient and leaves the scaled dividend over
      qmag = (longint'(1) << div_pkg::ACC_BITS) - 1;
      rmag = a << div_pkg::Q_BITS;
    end else begin
      qmag = (a << div_pkg::Q_BITS) / b;
      rmag = (a << div_pkg::Q_BITS) % b;
    end
    q16 = qmag[div_pkg::N_BITS-1:0];
    r16 = rmag[div_pkg::N_BITS-1:0];
    r.quotient  = sgn ? -q16 : q16;
    r.remainder = sgn ? -r16 : r16;
    r.overflow  = (qmag > ((longint'(1) << (div_pkg::N_BITS - 1)) - 1));
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    n_checks++;
    if (got !== expected) begin
      n_mismatch++;
      $display("MISMATCH %s: got 0x%0h expected 0x%0h at cycle %0d",
               name, got, expected, cycle_cnt);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // Presents one request and waits for the accepting edge
  task automatic send_req(input div_pkg::div_req_t req, input int gap, input bit hold,
                          input bit check_spacing);
    if (!hold) begin
      while (!in_ready) tick();
      repeat (gap) tick();
    end
    in_req   = req;
    in_valid = 1'b1;
    while (!in_ready) tick();
    tick();
    exp_q.push_back(model_divide(req));
    acc_q.push_back(cycle_cnt);
    // With in_valid held, the next accept lands in the out_valid cycle
    if (check_spacing) begin
      check_value("accept_spacing", cycle_cnt - last_accept, div_pkg::STEPS + 2);
    end
    last_accept = cycle_cnt;
    if (!hold) in_valid = 1'b0;
  endtask

  task automatic end_of_run();
    int unsigned n_assert;
    n_assert = dut.u_assertions.fail_cnt;
    $display("Summary: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
             n_checks, n_mismatch, n_other, n_assert);
    if (n_mismatch == 0 && n_other == 0 && n_assert == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  ////////////////////
  // Clock, timeout and monitor
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("TIMEOUT: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      n_other++;
      end_of_run();
    end
  end

  // Response monitor and scoreboard
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: out_valid rose with no request outstanding");
          n_other++;
        end else begin
          exp_rsp   = exp_q.pop_front();
          acc_cycle = acc_q.pop_front();
          check_value("out_rsp.quotient", $unsigned(out_rsp.quotient),
                      $unsigned(exp_rsp.quotient));
          check_value("out_rsp.remainder", $unsigned(out_rsp.remainder),
                      $unsigned(exp_rsp.remainder));
          check_value("out_rsp.overflow", out_rsp.overflow, exp_rsp.overflow);
          check_value("latency", cycle_cnt - acc_cycle, div_pkg::STEPS + 1);
        end
      end else if (exp_q.size() != 0) begin
        check_value("in_ready", in_ready, 1'b0);
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [31:0]                r;
    logic [div_pkg::N_BITS-1:0] a;
    logic [div_pkg::N_BITS-1:0] b;
    div_pkg::div_req_t          req;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_req      = '0;
    cycle_cnt   = 0;
    last_accept = 0;
    n_checks    = 0;
    n_mismatch  = 0;
    n_other     = 0;
    lfsr_state  = 32'd80800;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();
    check_value("in_ready", in_ready, 1'b1);
    check_value("out_valid", out_valid, 1'b0);

    // Random pairs whose sign bits cycle through all four combinations
    for (int i = 0; i < N_RAND; i++) begin
      rand_bits(16, r);
      a = r[15:0];
      rand_bits(16, r);
      b = r[15:0];
      a[div_pkg::N_BITS-1] = i[0];
      b[div_pkg::N_BITS-1] = i[1];
      req.dividend = a;
      req.divisor  = b;
      rand_bits(1, r);
      send_req(req, r[0], 1'b0, 1'b0);
    end

    // Small divisors against dividends of varied size around the overflow limit
    for (int i = 0; i < N_SMALL; i++) begin
      rand_bits(8, r);
      b = r[15:0] | 16'h0001;
      rand_bits(15, r);
      a = r[15:0];
      rand_bits(4, r);
      a = a >> r[3:0];
      rand_bits(2, r);
      req.dividend = r[0] ? -a : a;
      req.divisor  = r[1] ? -b : b;
      rand_bits(1, r);
      send_req(req, r[0], 1'b0, 1'b0);
    end

    for (int i = 0; i < N_CORNER; i++) begin
      req.dividend = corner_a[i];
      req.divisor  = corner_b[i];
      send_req(req, 0, 1'b0, 1'b0);
    end

    // Back-to-back requests with in_valid held. Spacing is timed from the second accept on
    for (int i = 0; i < N_B2B; i++) begin
      rand_bits(16, r);
      req.dividend = r[15:0];
      rand_bits(16, r);
      req.divisor = r[15:0];
      send_req(req, 0, 1'b1, i != 0);
    end
    in_valid = 1'b0;

    // Wait for the remaining responses to drain
    while (exp_q.size() != 0) tick();
    repeat (4) tick();
    end_of_run();
  end

endmodule

`default_nettype wire
